// File: Bender.yml
package:
  name: cpu

sources:
  - cpu_pkg.sv
  - fetch_stage.sv
  - decoder.sv
  - register_file.sv
  - alu.sv
  - hazard_unit.sv
  - cpu.sv
  - target: test
    files:
      - cpu_checker.sv
      - tb_cpu.sv

// File: alu.sv
module alu (
	input  cpu_pkg::alu_op_e  i_op,
	input  cpu_pkg::word_t    i_a,
	input  cpu_pkg::word_t    i_b,
	output cpu_pkg::word_t    o_result
);
	import cpu_pkg::*;

	always_comb begin
		case (i_op)
			ALU_ADD: begin
				o_result = i_a + i_b;
			end
			ALU_SUB: begin
				o_result = i_a - i_b;
			end
			ALU_AND: begin
				o_result = i_a & i_b;
			end
			ALU_OR: begin
				o_result = i_a | i_b;
			end
			ALU_NOT: begin
				o_result = ~i_a;
			end
			ALU_TCP: begin
				o_result = ~i_a + 16'd1;
			end
			ALU_SHL: begin
				o_result = {i_a[14:0], 1'b0};
			end
			ALU_SHR: begin
				// sign bit is kept
				o_result = {i_a[15], i_a[15:1]};
			end
			default: begin
				o_result = i_b;
			end
		endcase
	end

endmodule

// File: cpu.sv
module cpu #(
	parameter cpu_pkg::word_t RESET_PC = '0
) (
	input  logic               clk,
	input  logic               reset_n,
	input  cpu_pkg::word_t     i_inst_data,
	input  cpu_pkg::word_t     i_mem_rdata,
	output cpu_pkg::word_t     o_inst_addr,
	output cpu_pkg::mem_req_t  o_mem_req,
	output cpu_pkg::word_t     o_num_inst,
	output cpu_pkg::word_t     o_output_port,
	output logic               o_is_halted
);
	import cpu_pkg::*;

	if_id_t if_id;
	ctrl_t id_ctrl;
	id_ex_t id_ex;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;
	word_t rs_val;
	word_t rt_val;
	logic stall;
	fwd_sel_e fwd_a;
	fwd_sel_e fwd_b;
	word_t op_a;
	word_t op_b;
	word_t alu_result;
	word_t wb_data;

	function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val);
		case (sel)
			FWD_EX_MEM: return ex_mem.alu_result;
			FWD_WB: return wb_data;
			default: return reg_val;
		endcase
	endfunction

	fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
		.clk(clk),
		.reset_n(reset_n),
		.i_stall(stall),
		.i_halt_decoded(id_ctrl.is_halt),
		.i_inst_data(i_inst_data),
		.o_inst_addr(o_inst_addr),
		.o_if_id(if_id)
	);

	decoder u_decoder (.i_instr(if_id.instr), .o_ctrl(id_ctrl));

	register_file u_regs (
		.clk(clk),
		.reset_n(reset_n),
		.i_rs(id_ctrl.rs),
		.i_rt(id_ctrl.rt),
		.i_we(mem_wb.reg_write),
		.i_wd_addr(mem_wb.dest),
		.i_wd(wb_data),
		.o_rs_val(rs_val),
		.o_rt_val(rt_val)
	);

	hazard_unit u_hazard (
		.i_id_ctrl(id_ctrl),
		.i_id_ex(id_ex),
		.i_ex_mem(ex_mem),
		.i_mem_wb(mem_wb),
		.o_stall(stall),
		.o_fwd_a(fwd_a),
		.o_fwd_b(fwd_b)
	);

	// bubble into EX while the load finishes
	always_ff @(posedge clk) begin
		if (!reset_n || stall) begin
			id_ex.ctrl <= '0;
		end
		else begin
			id_ex <= '{ctrl: id_ctrl, rs_val: rs_val, rt_val: rt_val};
		end
	end

	always_comb begin
		op_a = fwd_mux(fwd_a, id_ex.rs_val);
		op_b = fwd_mux(fwd_b, id_ex.rt_val);
	end

	alu u_alu (
		.i_op(id_ex.ctrl.alu_op),
		.i_a(op_a),
		.i_b(id_ex.ctrl.use_imm ? id_ex.ctrl.imm : op_b),
		.o_result(alu_result)
	);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			ex_mem.ctrl <= '0;
		end
		else begin
			ex_mem.ctrl <= '{dest: id_ex.ctrl.dest, reg_write: id_ex.ctrl.reg_write,
				mem_read: id_ex.ctrl.mem_read, mem_write: id_ex.ctrl.mem_write,
				is_wwd: id_ex.ctrl.is_wwd, is_halt: id_ex.ctrl.is_halt,
				valid: id_ex.ctrl.valid};
			ex_mem.alu_result <= alu_result;
			ex_mem.store_data <= op_b;
			ex_mem.rs_val <= op_a;
		end
	end

	assign o_mem_req = '{read: ex_mem.ctrl.mem_read, write: ex_mem.ctrl.mem_write,
		addr: ex_mem.alu_result, wdata: ex_mem.store_data};

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			mem_wb.reg_write <= 1'b0;
			mem_wb.is_wwd <= 1'b0;
			mem_wb.is_halt <= 1'b0;
			mem_wb.valid <= 1'b0;
			mem_wb.mem_read <= 1'b0;
		end
		else begin
			mem_wb.dest <= ex_mem.ctrl.dest;
			mem_wb.reg_write <= ex_mem.ctrl.reg_write;
			mem_wb.is_wwd <= ex_mem.ctrl.is_wwd;
			mem_wb.is_halt <= ex_mem.ctrl.is_halt;
			mem_wb.valid <= ex_mem.ctrl.valid;
			mem_wb.mem_read <= ex_mem.ctrl.mem_read;
			mem_wb.alu_result <= ex_mem.alu_result;
			mem_wb.load_data <= i_mem_rdata;
			mem_wb.rs_val <= ex_mem.rs_val;
		end
	end

	assign wb_data = mem_wb.mem_read ? mem_wb.load_data : mem_wb.alu_result;

	// retire point
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			o_num_inst <= '0;
			o_output_port <= '0;
			o_is_halted <= 1'b0;
		end
		else if (mem_wb.valid) begin
			o_num_inst <= o_num_inst + 16'd1;
			if (mem_wb.is_wwd) begin
				o_output_port <= mem_wb.rs_val;
			end
			if (mem_wb.is_halt) begin
				o_is_halted <= 1'b1;
			end
		end
	end

endmodule

// File: cpu_checker.sv
module cpu_checker (
	input  logic               clk,
	input  logic               reset_n,
	input  cpu_pkg::mem_req_t  i_mem_req,
	input  cpu_pkg::word_t     i_num_inst,
	input  logic               i_is_halted
);
	int assert_fails = 0;

	no_dual_strobe: assert property (@(posedge clk) disable iff (!reset_n)
		!(i_mem_req.read && i_mem_req.write))
		else begin
			$error("read and write strobes high together");
			assert_fails++;
		end

	// sync reset, so only a low reset_n at this edge may clear it
	halt_sticky: assert property (@(posedge clk) (reset_n && i_is_halted) |=> i_is_halted)
		else begin
			$error("o_is_halted fell without reset");
			assert_fails++;
		end

	count_step: assert property (@(posedge clk) reset_n |=>
		(i_num_inst == $past(i_num_inst) || i_num_inst == $past(i_num_inst) + 16'd1))
		else begin
			$error("o_num_inst rose by more than one");
			assert_fails++;
		end

endmodule

bind cpu cpu_checker u_checker (
	.clk(clk),
	.reset_n(reset_n),
	.i_mem_req(o_mem_req),
	.i_num_inst(o_num_inst),
	.i_is_halted(o_is_halted)
);

// File: cpu_pkg.sv
package cpu_pkg;

	localparam int WORD_W = 16;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [1:0] reg_addr_t;

	// opcode 11 decodes to nothing, so it serves as the bubble
	localparam word_t NOP_INSTR = 16'hb000;

	typedef enum logic [3:0] {
		OP_ADI   = 4'd4,
		OP_ORI   = 4'd5,
		OP_LHI   = 4'd6,
		OP_LWD   = 4'd7,
		OP_SWD   = 4'd8,
		OP_RTYPE = 4'd15
	} opcode_e;

	typedef enum logic [5:0] {
		FN_ADD = 6'd0,
		FN_SUB = 6'd1,
		FN_AND = 6'd2,
		FN_ORR = 6'd3,
		FN_NOT = 6'd4,
		FN_TCP = 6'd5,
		FN_SHL = 6'd6,
		FN_SHR = 6'd7,
		FN_WWD = 6'd28,
		FN_HLT = 6'd29
	} funct_e;

	// first eight follow the funct order
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_NOT,
		ALU_TCP,
		ALU_SHL,
		ALU_SHR,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {
		FWD_REG,
		FWD_EX_MEM,
		FWD_WB
	} fwd_sel_e;

	typedef struct packed {
		alu_op_e   alu_op;
		logic      use_imm;
		word_t     imm;
		reg_addr_t rs;
		reg_addr_t rt;
		logic      uses_rs;
		logic      uses_rt;
		reg_addr_t dest;
		logic      reg_write;
		logic      mem_read;
		logic      mem_write;
		logic      is_wwd;
		logic      is_halt;
		logic      valid;
	} ctrl_t;

	typedef struct packed {
		word_t pc;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t rs_val;
		word_t rt_val;
	} id_ex_t;

	// what still matters after EX
	typedef struct packed {
		reg_addr_t dest;
		logic      reg_write;
		logic      mem_read;
		logic      mem_write;
		logic      is_wwd;
		logic      is_halt;
		logic      valid;
	} mem_ctrl_t;

	typedef struct packed {
		mem_ctrl_t ctrl;
		word_t     alu_result;
		word_t     store_data;
		word_t     rs_val;
	} ex_mem_t;

	typedef struct packed {
		reg_addr_t dest;
		logic      reg_write;
		logic      is_wwd;
		logic      is_halt;
		logic      valid;
		logic      mem_read;
		word_t     alu_result;
		word_t     load_data;
		word_t     rs_val;
	} mem_wb_t;

	typedef struct packed {
		logic  read;
		logic  write;
		word_t addr;
		word_t wdata;
	} mem_req_t;

endpackage

// File: decoder.sv
module decoder (
	input  cpu_pkg::word_t  i_instr,
	output cpu_pkg::ctrl_t  o_ctrl
);
	import cpu_pkg::*;

	word_t sext_imm;
	word_t zext_imm;
	word_t upper_imm;

	assign sext_imm = {{8{i_instr[7]}}, i_instr[7:0]};
	assign zext_imm = {8'h00, i_instr[7:0]};
	assign upper_imm = {i_instr[7:0], 8'h00};

	always_comb begin
		o_ctrl = '0;
		o_ctrl.rs = i_instr[11:10];
		o_ctrl.rt = i_instr[9:8];
		// immediates write rt, R-type overrides below
		o_ctrl.dest = i_instr[9:8];
		case (opcode_e'(i_instr[15:12]))
			OP_RTYPE: begin
				o_ctrl.dest = i_instr[7:6];
				case (funct_e'(i_instr[5:0]))
					FN_ADD, FN_SUB, FN_AND, FN_ORR, FN_NOT, FN_TCP, FN_SHL, FN_SHR: begin
						o_ctrl.alu_op = alu_op_e'(i_instr[2:0]);
						o_ctrl.uses_rs = 1'b1;
						// unary ops only read rs
						o_ctrl.uses_rt = ~i_instr[2];
						o_ctrl.reg_write = 1'b1;
						o_ctrl.valid = 1'b1;
					end
					FN_WWD: begin
						o_ctrl.uses_rs = 1'b1;
						o_ctrl.is_wwd = 1'b1;
						o_ctrl.valid = 1'b1;
					end
					FN_HLT: begin
						o_ctrl.is_halt = 1'b1;
						o_ctrl.valid = 1'b1;
					end
					default: begin
						o_ctrl.valid = 1'b0;
					end
				endcase
			end
			OP_ADI, OP_ORI, OP_LWD, OP_SWD: begin
				o_ctrl.alu_op = (i_instr[15:12] == OP_ORI) ? ALU_OR : ALU_ADD;
				o_ctrl.use_imm = 1'b1;
				o_ctrl.imm = (i_instr[15:12] == OP_ORI) ? zext_imm : sext_imm;
				o_ctrl.uses_rs = 1'b1;
				o_ctrl.uses_rt = (i_instr[15:12] == OP_SWD);
				o_ctrl.reg_write = (i_instr[15:12] != OP_SWD);
				o_ctrl.mem_read = (i_instr[15:12] == OP_LWD);
				o_ctrl.mem_write = (i_instr[15:12] == OP_SWD);
				o_ctrl.valid = 1'b1;
			end
			OP_LHI: begin
				o_ctrl.alu_op = ALU_PASS_B;
				o_ctrl.use_imm = 1'b1;
				o_ctrl.imm = upper_imm;
				o_ctrl.reg_write = 1'b1;
				o_ctrl.valid = 1'b1;
			end
			default: begin
				o_ctrl.valid = 1'b0;
			end
		endcase
	end

endmodule

// File: fetch_stage.sv
module fetch_stage #(
	parameter cpu_pkg::word_t RESET_PC = '0
) (
	input  logic             clk,
	input  logic             reset_n,
	input  logic             i_stall,
	input  logic             i_halt_decoded,
	input  cpu_pkg::word_t   i_inst_data,
	output cpu_pkg::word_t   o_inst_addr,
	output cpu_pkg::if_id_t  o_if_id
);
	import cpu_pkg::*;

	word_t pc;
	logic stopped;

	assign o_inst_addr = pc;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= RESET_PC;
			stopped <= 1'b0;
			o_if_id.pc <= RESET_PC;
			o_if_id.instr <= NOP_INSTR;
		end
		else if (!i_stall) begin
			if (stopped || i_halt_decoded) begin
				// nothing behind HLT may enter decode
				stopped <= 1'b1;
				o_if_id.instr <= NOP_INSTR;
			end
			else begin
				pc <= pc + 16'd1;
				o_if_id.pc <= pc;
				o_if_id.instr <= i_inst_data;
			end
		end
	end

endmodule

// File: hazard_unit.sv
module hazard_unit (
	input  cpu_pkg::ctrl_t     i_id_ctrl,
	input  cpu_pkg::id_ex_t    i_id_ex,
	input  cpu_pkg::ex_mem_t   i_ex_mem,
	input  cpu_pkg::mem_wb_t   i_mem_wb,
	output logic               o_stall,
	output cpu_pkg::fwd_sel_e  o_fwd_a,
	output cpu_pkg::fwd_sel_e  o_fwd_b
);
	import cpu_pkg::*;

	logic rs_hit;
	logic rt_hit;

	// younger stage wins when both hold the register
	function automatic fwd_sel_e pick_source(input reg_addr_t src);
		if (i_ex_mem.ctrl.reg_write && i_ex_mem.ctrl.dest == src) begin
			return FWD_EX_MEM;
		end
		if (i_mem_wb.reg_write && i_mem_wb.dest == src) begin
			return FWD_WB;
		end
		return FWD_REG;
	endfunction

	// load data arrives one stage too late for the next instruction
	assign rs_hit = i_id_ctrl.uses_rs && i_id_ctrl.rs == i_id_ex.ctrl.dest;
	assign rt_hit = i_id_ctrl.uses_rt && i_id_ctrl.rt == i_id_ex.ctrl.dest;
	assign o_stall = i_id_ex.ctrl.valid && i_id_ex.ctrl.mem_read && (rs_hit || rt_hit);

	always_comb begin
		o_fwd_a = pick_source(i_id_ex.ctrl.rs);
		o_fwd_b = pick_source(i_id_ex.ctrl.rt);
	end

endmodule

// File: list.f
cpu_pkg.sv
fetch_stage.sv
decoder.sv
register_file.sv
alu.sv
hazard_unit.sv
cpu.sv
cpu_checker.sv
tb_cpu.sv

// File: register_file.sv
module register_file (
	input  logic                 clk,
	input  logic                 reset_n,
	input  cpu_pkg::reg_addr_t   i_rs,
	input  cpu_pkg::reg_addr_t   i_rt,
	input  logic                 i_we,
	input  cpu_pkg::reg_addr_t   i_wd_addr,
	input  cpu_pkg::word_t       i_wd,
	output cpu_pkg::word_t       o_rs_val,
	output cpu_pkg::word_t       o_rt_val
);
	import cpu_pkg::*;

	word_t regs [4];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
		end
		else if (i_we) begin
			regs[i_wd_addr] <= i_wd;
		end
	end

	// write-through so decode sees the value retiring this cycle
	assign o_rs_val = (i_we && i_rs == i_wd_addr) ? i_wd : regs[i_rs];
	assign o_rt_val = (i_we && i_rt == i_wd_addr) ? i_wd : regs[i_rt];

endmodule

// File: tb_cpu.sv
module tb_cpu;
	import cpu_pkg::*;

	localparam int SEED = 8639;
	localparam int PROG_LEN = 40;
	localparam int NUM_PROGS = 20;
	localparam int TIMEOUT = 400;
	localparam int DRIVE_DLY = 2;

	logic clk;
	logic reset_n;
	word_t inst_data;
	word_t mem_rdata;
	word_t inst_addr;
	mem_req_t mem_req;
	word_t num_inst;
	word_t output_port;
	logic is_halted;

	word_t imem [64];
	word_t dmem [256];
	word_t model_regs [4];
	word_t model_mem [256];
	word_t store_addr_q [$];
	word_t store_data_q [$];
	word_t load_addr_q [$];
	int seed;
	int mismatches;
	int failures;
	logic timed_out;

	cpu #(.RESET_PC('0)) u_dut (
		.clk(clk),
		.reset_n(reset_n),
		.i_inst_data(inst_data),
		.i_mem_rdata(mem_rdata),
		.o_inst_addr(inst_addr),
		.o_mem_req(mem_req),
		.o_num_inst(num_inst),
		.o_output_port(output_port),
		.o_is_halted(is_halted)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// both memories answer in the same cycle
	assign inst_data = (inst_addr < 16'd64) ? imem[inst_addr[5:0]] : NOP_INSTR;
	assign mem_rdata = dmem[mem_req.addr[7:0]];

	always @(posedge clk) begin
		if (mem_req.write) begin
			dmem[mem_req.addr[7:0]] <= mem_req.wdata;
		end
	end

	function automatic int rand_below(input int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fffffff) % n;
	endfunction

	task automatic show_mismatch(input string name, input word_t got, input word_t exp);
		$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		mismatches++;
	endtask

	task automatic log_failure(input string msg);
		$display("Error at %0t: %s", $time, msg);
		failures++;
	endtask

	task automatic build_program(input int p);
		int kind;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		logic [7:0] imm;
		reg_addr_t load_dest;
		logic prev_load;
		prev_load = 1'b0;
		load_dest = '0;
		for (int a = 0; a < 64; a++) begin
			imem[a] = NOP_INSTR;
		end
		for (int a = 0; a < 256; a++) begin
			dmem[a] = {8'(a) ^ 8'(p), ~8'(a)};
			model_mem[a] = dmem[a];
		end
		for (int i = 0; i < 4; i++) begin
			model_regs[i] = '0;
		end
		for (int i = 0; i < PROG_LEN - 1; i++) begin
			kind = rand_below(16);
			rs = 2'(rand_below(4));
			rt = 2'(rand_below(4));
			rd = 2'(rand_below(4));
			imm = 8'(rand_below(256));
			// extra loads and frequent load-then-use pairs
			if (kind >= 14) begin
				kind = 12;
			end
			if (prev_load && rand_below(2) == 0) begin
				rs = load_dest;
			end
			case (kind)
				8: imem[i] = {OP_RTYPE, rs, 4'h0, FN_WWD};
				9: imem[i] = {OP_ADI, rs, rt, imm};
				10: imem[i] = {OP_ORI, rs, rt, imm};
				11: imem[i] = {OP_LHI, rs, rt, imm};
				12: imem[i] = {OP_LWD, rs, rt, imm};
				13: imem[i] = {OP_SWD, rs, rt, imm};
				default: imem[i] = {OP_RTYPE, rs, rt, rd, 6'(kind)};
			endcase
			prev_load = (kind == 12);
			load_dest = rt;
		end
		imem[PROG_LEN-1] = {OP_RTYPE, 6'h00, FN_HLT};
	endtask

	// ISA semantics stepped once per retirement
	task automatic retire_model(input int idx);
		word_t instr;
		word_t a;
		word_t b;
		word_t addr;
		word_t got_addr;
		word_t got_data;
		reg_addr_t rd;
		instr = imem[idx];
		a = model_regs[instr[11:10]];
		b = model_regs[instr[9:8]];
		rd = instr[7:6];
		addr = a + {{8{instr[7]}}, instr[7:0]};
		case (instr[15:12])
			OP_ADI: model_regs[instr[9:8]] = addr;
			OP_ORI: model_regs[instr[9:8]] = a | {8'h00, instr[7:0]};
			OP_LHI: model_regs[instr[9:8]] = {instr[7:0], 8'h00};
			OP_LWD: begin
				model_regs[instr[9:8]] = model_mem[addr[7:0]];
				if (load_addr_q.size() == 0) begin
					log_failure("load retired without a read strobe");
				end
				else begin
					got_addr = load_addr_q.pop_front();
					if (got_addr != addr) show_mismatch("o_mem_req.addr", got_addr, addr);
				end
			end
			OP_SWD: begin
				model_mem[addr[7:0]] = b;
				if (store_addr_q.size() == 0) begin
					log_failure("store retired without a write strobe");
				end
				else begin
					got_addr = store_addr_q.pop_front();
					got_data = store_data_q.pop_front();
					if (got_addr != addr) show_mismatch("o_mem_req.addr", got_addr, addr);
					if (got_data != b) show_mismatch("o_mem_req.wdata", got_data, b);
				end
			end
			default: begin
				case (instr[5:0])
					FN_ADD: model_regs[rd] = a + b;
					FN_SUB: model_regs[rd] = a - b;
					FN_AND: model_regs[rd] = a & b;
					FN_ORR: model_regs[rd] = a | b;
					FN_NOT: model_regs[rd] = ~a;
					FN_TCP: model_regs[rd] = 16'd0 - a;
					FN_SHL: model_regs[rd] = a << 1;
					FN_SHR: model_regs[rd] = $signed(a) >>> 1;
					FN_WWD: begin
						if (output_port != a) show_mismatch("o_output_port", output_port, a);
					end
					default: begin
					end
				endcase
			end
		endcase
	endtask

	task automatic reset_dut(input int p);
		@(posedge clk);
		#DRIVE_DLY;
		reset_n = 1'b0;
		build_program(p);
		repeat (4) begin
			@(posedge clk);
		end
		#DRIVE_DLY;
		if (num_inst != '0) show_mismatch("o_num_inst", num_inst, '0);
		if (output_port != '0) show_mismatch("o_output_port", output_port, '0);
		if (is_halted) show_mismatch("o_is_halted", 16'(is_halted), '0);
		if (mem_req.read) show_mismatch("o_mem_req.read", 16'(mem_req.read), '0);
		if (mem_req.write) show_mismatch("o_mem_req.write", 16'(mem_req.write), '0);
		reset_n = 1'b1;
	endtask

	task automatic run_program();
		int cycles;
		int retired;
		cycles = 0;
		retired = 0;
		store_addr_q.delete();
		store_data_q.delete();
		load_addr_q.delete();
		while (!is_halted && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
			if (mem_req.write) begin
				store_addr_q.push_back(mem_req.addr);
				store_data_q.push_back(mem_req.wdata);
			end
			if (mem_req.read) begin
				load_addr_q.push_back(mem_req.addr);
			end
			if (num_inst != 16'(retired)) begin
				if (num_inst != 16'(retired + 1)) begin
					show_mismatch("o_num_inst", num_inst, 16'(retired + 1));
				end
				if (retired < PROG_LEN) begin
					retire_model(retired);
				end
				retired++;
			end
		end
		if (!is_halted) begin
			log_failure("timed out waiting for o_is_halted");
			timed_out = 1'b1;
		end
		else begin
			if (num_inst != 16'(PROG_LEN)) show_mismatch("o_num_inst", num_inst, 16'(PROG_LEN));
			// halted core stays quiet
			repeat (10) begin
				@(negedge clk);
				if (mem_req.read || mem_req.write) log_failure("memory strobe after halt");
				if (!is_halted) log_failure("o_is_halted fell after halt");
				if (num_inst != 16'(PROG_LEN)) begin
					show_mismatch("o_num_inst", num_inst, 16'(PROG_LEN));
				end
			end
			if (store_addr_q.size() != 0) log_failure("write strobe with no retired store");
			if (load_addr_q.size() != 0) log_failure("read strobe with no retired load");
			for (int a = 0; a < 256; a++) begin
				if (dmem[a] != model_mem[a]) begin
					show_mismatch($sformatf("dmem[%0d]", a), dmem[a], model_mem[a]);
				end
			end
		end
	endtask

	initial begin
		seed = SEED;
		mismatches = 0;
		failures = 0;
		timed_out = 1'b0;
		reset_n = 1'b0;
		for (int a = 0; a < 64; a++) begin
			imem[a] = NOP_INSTR;
		end
		for (int a = 0; a < 256; a++) begin
			dmem[a] = '0;
		end
		for (int p = 0; p < NUM_PROGS && !timed_out; p++) begin
			reset_dut(p);
			run_program();
		end
		$display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatches, failures, u_dut.u_checker.assert_fails);
		if (mismatches + failures + u_dut.u_checker.assert_fails == 0) begin
			$display("test passed");
		end
		else begin
			$display("test failed");
		end
		$finish;
	end

endmodule
